// File: design/sys_pkg.sv
/*
 * Shared widths, command codes and reset values for the board glue logic.
 * Every design module imports this package.
 */
package sys_pkg;

	// ====================
	// Word types
	// ====================
	typedef logic [31:0] host_word_t;
	typedef logic [15:0] io_word_t;
	typedef logic [11:0] timing_t;
	typedef logic [7:0]  cmd_t;
	typedef logic [1:0]  rst_code_t;

	// Sync pulse run length, wide enough for a full frame at 50 MHz
	typedef logic [23:0] run_len_t;

	// ====================
	// Host protocol
	// ====================
	localparam cmd_t cmd_config = 8'h01;
	localparam cmd_t cmd_timing = 8'h20;

	// Host refuses to talk to a core with a different magic
	localparam host_word_t core_magic = 32'h5CA6_23A4;
	localparam logic [1:0] io_version = 2'd1;

	localparam int num_timing_words = 8;

	// Host reset codes on gp_out[31:30]
	localparam rst_code_t rst_code_guard = 2'd0;
	localparam rst_code_t rst_code_set   = 2'd1;
	localparam rst_code_t rst_code_clear = 2'd2;

	// ====================
	// Reset defaults
	// ====================
	// 1280x720 at 60 Hz
	localparam timing_t default_width  = 12'd1280;
	localparam timing_t default_hfp    = 12'd110;
	localparam timing_t default_hs     = 12'd40;
	localparam timing_t default_hbp    = 12'd220;
	localparam timing_t default_height = 12'd720;
	localparam timing_t default_vfp    = 12'd5;
	localparam timing_t default_vs     = 12'd5;
	localparam timing_t default_vbp    = 12'd20;

	// Button sampling
	localparam int debounce_div_default = 100000;
	localparam int deb_len = 8;

	// Command decoder states
	typedef enum logic {
		idle,
		have_cmd
	} dec_state_t;

endpackage

// File: design/host_link.sv
/*
 * Host word port. Captures the host output word, runs the strobe and
 * acknowledge handshake and returns either the magic or the status word.
 */
`timescale 1ns/1ps

module host_link (
	input  logic                FPGA_CLK2_50,
	input  logic                resetd,
	input  sys_pkg::host_word_t gp_out,
	input  logic                io_wait,
	input  logic                btn_user_db,
	input  logic                btn_osd_db,
	output sys_pkg::host_word_t gp_in,
	output sys_pkg::io_word_t   io_data,
	output logic                io_uio,
	output logic                io_strobe,
	output sys_pkg::rst_code_t  reset_code,
	output logic                disk_act
);
	import sys_pkg::*;

	host_word_t gp_out_d;
	host_word_t gp_out_r;
	host_word_t status_word;
	logic       io_clk;
	logic       rack;
	logic       io_ack;

	// Two-stage capture of the host word
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			gp_out_d <= '0;
			gp_out_r <= '0;
		end else begin
			gp_out_d <= gp_out;
			gp_out_r <= gp_out_d;
		end
	end

	assign io_data    = gp_out_r[15:0];
	assign io_clk     = gp_out_r[17];
	assign io_uio     = gp_out_r[20];
	assign disk_act   = gp_out_r[29];
	assign reset_code = gp_out_r[31:30];

	// One strobe per io_clk rise
	assign io_strobe = io_clk & ~rack;

	// Ack stalls while the core holds io_wait
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else if (!io_wait || io_strobe) begin
			rack   <= io_clk;
			io_ack <= rack;
		end
	end

	assign status_word = {1'b0, btn_user_db, btn_osd_db, 9'd0, io_version, io_ack, 17'd0};

	// Bit 31 low asks for the magic word
	assign gp_in = gp_out[31] ? status_word : core_magic;

endmodule

// File: design/config_decoder.sv
/*
 * Command decoder for host frames. Command 1 loads the configuration flags,
 * command 0x20 loads the eight video timing words in order.
 */
`timescale 1ns/1ps

module config_decoder (
	input  logic              FPGA_CLK2_50,
	input  logic              resetd,
	input  logic              io_strobe,
	input  logic              io_uio,
	input  sys_pkg::io_word_t io_data,
	output logic              dvi_mode,
	output logic              audio_96k,
	output logic              ypbpr_en,
	output logic              csync,
	output logic              vga_scaler,
	output sys_pkg::timing_t  h_width,
	output sys_pkg::timing_t  h_fp,
	output sys_pkg::timing_t  h_sync,
	output sys_pkg::timing_t  h_bp,
	output sys_pkg::timing_t  v_height,
	output sys_pkg::timing_t  v_fp,
	output sys_pkg::timing_t  v_sync,
	output sys_pkg::timing_t  v_bp
);
	import sys_pkg::*;

	dec_state_t state;
	cmd_t       cmd;
	logic [3:0] word_cnt;
	logic       old_strobe;
	logic       strobe_rise;

	assign strobe_rise = io_strobe & ~old_strobe;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			state      <= idle;
			cmd        <= '0;
			word_cnt   <= '0;
			old_strobe <= 1'b0;
			dvi_mode   <= 1'b0;
			audio_96k  <= 1'b0;
			ypbpr_en   <= 1'b0;
			csync      <= 1'b0;
			vga_scaler <= 1'b0;
			h_width    <= default_width;
			h_fp       <= default_hfp;
			h_sync     <= default_hs;
			h_bp       <= default_hbp;
			v_height   <= default_height;
			v_fp       <= default_vfp;
			v_sync     <= default_vs;
			v_bp       <= default_vbp;
		end else begin
			old_strobe <= io_strobe;

			// Frame ends when io_uio drops
			if (!io_uio) begin
				state <= idle;
			end else if (strobe_rise) begin
				case (state)
					idle: begin
						cmd      <= io_data[7:0];
						word_cnt <= '0;
						state    <= have_cmd;
					end
					have_cmd: begin
						if (cmd == cmd_config) begin
							dvi_mode   <= io_data[7];
							audio_96k  <= io_data[6];
							ypbpr_en   <= io_data[5];
							csync      <= io_data[3];
							vga_scaler <= io_data[2];
						end else if (cmd == cmd_timing &&
							word_cnt < 4'(num_timing_words)) begin
							word_cnt <= word_cnt + 4'd1;
							case (word_cnt[2:0])
								3'd0: h_width  <= io_data[11:0];
								3'd1: h_fp     <= io_data[11:0];
								3'd2: h_sync   <= io_data[11:0];
								3'd3: h_bp     <= io_data[11:0];
								3'd4: v_height <= io_data[11:0];
								3'd5: v_fp     <= io_data[11:0];
								3'd6: v_sync   <= io_data[11:0];
								default: v_bp  <= io_data[11:0];
							endcase
						end
						// other commands belong to blocks outside this design
					end
				endcase
			end
		end
	end

endmodule

// File: design/button_debounce.sv
/*
 * Debounces the user and OSD buttons. Both are sampled once per slow tick
 * and change state only after a full history of equal samples.
 */
`timescale 1ns/1ps

module button_debounce #(
	parameter int debounce_div = sys_pkg::debounce_div_default
) (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  logic       btn_user,
	input  logic       btn_osd,
	input  logic [1:0] key,
	output logic       btn_user_db,
	output logic       btn_osd_db
);
	import sys_pkg::*;

	logic [31:0]        div_cnt;
	logic               tick;
	logic [deb_len-1:0] deb_user;
	logic [deb_len-1:0] deb_osd;

	// Sample tick, one every debounce_div+1 clocks
	assign tick = (div_cnt == 32'd0);

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd || div_cnt >= 32'(debounce_div))
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 32'd1;
	end

	// Buttons and keys are active low
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			deb_user    <= '0;
			deb_osd     <= '0;
			btn_user_db <= 1'b0;
			btn_osd_db  <= 1'b0;
		end else if (tick) begin
			deb_user <= {deb_user[deb_len-2:0], ~(btn_user & key[1])};
			deb_osd  <= {deb_osd[deb_len-2:0], ~(btn_osd & key[0])};

			if (&deb_user) btn_user_db <= 1'b1;
			if (~|deb_user) btn_user_db <= 1'b0;
			if (&deb_osd) btn_osd_db <= 1'b1;
			if (~|deb_osd) btn_osd_db <= 1'b0;
		end
	end

endmodule

// File: design/reset_request.sv
/*
 * Host reset request with a guard sequence, so a stray code cannot release
 * the reset. Also registers the cold-reset button.
 */
`timescale 1ns/1ps

module reset_request (
	input  logic               FPGA_CLK2_50,
	input  logic               resetd,
	input  sys_pkg::rst_code_t reset_code,
	input  logic               btn_reset,
	output logic               reset_req,
	output logic               cold_reset
);
	import sys_pkg::*;

	rst_code_t code_d1;
	rst_code_t code_d2;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			code_d1    <= rst_code_guard;
			code_d2    <= rst_code_guard;
			reset_req  <= 1'b0;
			cold_reset <= 1'b0;
		end else begin
			code_d1 <= reset_code;
			code_d2 <= code_d1;

			if (code_d1 == rst_code_set)
				reset_req <= 1'b1;
			// Release only when clear follows the guard code
			if (code_d1 == rst_code_clear && code_d2 == rst_code_guard)
				reset_req <= 1'b0;

			// Button is active low
			cold_reset <= ~btn_reset;
		end
	end

endmodule

// File: design/video_sync_out.sv
/*
 * VGA sync outputs. Each sync line is measured and its polarity turned so
 * the pulse is active high, then driven inverted or as composite sync.
 */
`timescale 1ns/1ps

module video_sync_out (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic hs_in,
	input  logic vs_in,
	input  logic csync,
	input  logic vga_en,
	output logic vga_hs,
	output logic vga_vs
);
	import sys_pkg::*;

	logic [1:0] sync_in;
	logic [1:0] sync_norm;
	logic [1:0] pol;
	logic [1:0] s1;
	logic [1:0] s2;
	run_len_t   run_cnt [2];
	run_len_t   high_w  [2];
	run_len_t   low_w   [2];

	// Index 0 is hsync, index 1 is vsync
	assign sync_in = {vs_in, hs_in};

	for (genvar i = 0; i < 2; i++) begin : g_line
		always_ff @(posedge FPGA_CLK2_50) begin
			if (resetd) begin
				s1[i]      <= 1'b0;
				s2[i]      <= 1'b0;
				run_cnt[i] <= '0;
				high_w[i]  <= '0;
				low_w[i]   <= '0;
				pol[i]     <= 1'b0;
			end else begin
				s1[i] <= sync_in[i];
				s2[i] <= s1[i];

				// Latch the width of the run that just ended
				if (!s2[i] && s1[i]) low_w[i] <= run_cnt[i];
				if (s2[i] && !s1[i]) high_w[i] <= run_cnt[i];

				if (s2[i] != s1[i])
					run_cnt[i] <= '0;
				else if (~&run_cnt[i])
					run_cnt[i] <= run_cnt[i] + 1'b1;

				// Longer high phase means active-low sync
				pol[i] <= (high_w[i] > low_w[i]);
			end
		end

		assign sync_norm[i] = sync_in[i] ^ pol[i];
	end

	// ====================
	// Output drive
	// ====================
	assign vga_hs = vga_en ? 1'b1 :
		csync ? ~(sync_norm[1] ^ sync_norm[0]) : ~sync_norm[0];
	assign vga_vs = vga_en ? 1'b1 :
		csync ? 1'b1 : ~sync_norm[1];

endmodule

// File: design/sys_top.sv
/*
 * Board glue top level. Connects the host port, command decoder, buttons,
 * reset request and VGA sync, and maps the LED requests to the board.
 */
`timescale 1ns/1ps

module sys_top #(
	parameter int debounce_div = sys_pkg::debounce_div_default
) (
	input  logic                FPGA_CLK2_50,
	input  logic                resetd,
	input  sys_pkg::host_word_t gp_out,
	output sys_pkg::host_word_t gp_in,
	input  logic                io_wait,
	input  logic                btn_user,
	input  logic                btn_osd,
	input  logic                btn_reset,
	input  logic [1:0]          key,
	input  logic                led_user_req,
	input  logic [1:0]          led_power_req,
	input  logic [1:0]          led_disk_req,
	input  logic                hs_in,
	input  logic                vs_in,
	input  logic                vga_en,
	output logic                vga_hs,
	output logic                vga_vs,
	output logic                led_user,
	output logic                led_hdd,
	output logic                led_power,
	output logic [7:0]          led,
	output logic                reset_req,
	output logic                cold_reset,
	output logic                dvi_mode,
	output logic                audio_96k,
	output logic                ypbpr_en,
	output logic                vga_scaler,
	output sys_pkg::timing_t    h_width,
	output sys_pkg::timing_t    h_fp,
	output sys_pkg::timing_t    h_sync,
	output sys_pkg::timing_t    h_bp,
	output sys_pkg::timing_t    v_height,
	output sys_pkg::timing_t    v_fp,
	output sys_pkg::timing_t    v_sync,
	output sys_pkg::timing_t    v_bp,
	output logic                io_strobe,
	output sys_pkg::io_word_t   io_data
);
	import sys_pkg::*;

	rst_code_t reset_code;
	logic      io_uio;
	logic      disk_act;
	logic      btn_user_db;
	logic      btn_osd_db;
	logic      csync;
	logic      led_p;
	logic      led_d;
	logic      led_u;

	host_link u_host_link (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.gp_out       (gp_out),
		.io_wait      (io_wait),
		.btn_user_db  (btn_user_db),
		.btn_osd_db   (btn_osd_db),
		.gp_in        (gp_in),
		.io_data      (io_data),
		.io_uio       (io_uio),
		.io_strobe    (io_strobe),
		.reset_code   (reset_code),
		.disk_act     (disk_act)
	);

	config_decoder u_config_decoder (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.io_strobe    (io_strobe),
		.io_uio       (io_uio),
		.io_data      (io_data),
		.dvi_mode     (dvi_mode),
		.audio_96k    (audio_96k),
		.ypbpr_en     (ypbpr_en),
		.csync        (csync),
		.vga_scaler   (vga_scaler),
		.h_width      (h_width),
		.h_fp         (h_fp),
		.h_sync       (h_sync),
		.h_bp         (h_bp),
		.v_height     (v_height),
		.v_fp         (v_fp),
		.v_sync       (v_sync),
		.v_bp         (v_bp)
	);

	button_debounce #(
		.debounce_div (debounce_div)
	) u_button_debounce (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.key          (key),
		.btn_user_db  (btn_user_db),
		.btn_osd_db   (btn_osd_db)
	);

	reset_request u_reset_request (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.reset_code   (reset_code),
		.btn_reset    (btn_reset),
		.reset_req    (reset_req),
		.cold_reset   (cold_reset)
	);

	video_sync_out u_video_sync_out (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.hs_in        (hs_in),
		.vs_in        (vs_in),
		.csync        (csync),
		.vga_en       (vga_en),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs)
	);

	// ====================
	// LEDs
	// ====================
	// Upper request bit selects direct drive
	assign led_p = led_power_req[1] ? ~led_power_req[0] : 1'b0;
	assign led_d = led_disk_req[1] ? ~led_disk_req[0] : ~(led_disk_req[0] | disk_act);
	assign led_u = ~led_user_req;

	assign led_power = led_p;
	assign led_hdd   = led_d;
	assign led_user  = led_u;

	// Main board LEDs
	assign led = {3'b000, ~led_p, 1'b0, ~led_d, 1'b0, ~led_u};

endmodule

// File: tb/host_tasks.svh
/*
 * Host side tasks for the board glue testbench. Included inside the testbench
 * module, they drive the host word port, run handshaked writes and sync lines.
 */

// Inputs change 1 ns after the rising edge
task automatic next_cycle();
	@(posedge FPGA_CLK2_50);
	#1;
endtask

// Polls one status word bit while gp_out[31] is high
task automatic wait_status_bit(input int bit_idx, input logic value, input int limit);
	int n;
	n = 0;
	next_cycle();
	while (gp_in[bit_idx] !== value && n < limit) begin
		next_cycle();
		n++;
	end
	assert (gp_in[bit_idx] === value) else begin
		$display("Status bit %0d did not reach %0b within %0d cycles (time %0t)",
			bit_idx, value, limit, $time);
		errors++;
	end
endtask

// Data stays put until io_ack follows io_clk both ways
task automatic write_word(input logic [15:0] data);
	next_cycle();
	gp_out[15:0] = data;
	gp_out[17] = 1'b1;
	wait_status_bit(17, 1'b1, ack_limit);
	expect_eq(io_data, data, "io_data during write");
	gp_out[17] = 1'b0;
	wait_status_bit(17, 1'b0, ack_limit);
endtask

task automatic start_frame();
	next_cycle();
	gp_out[20] = 1'b1;
endtask

// Decoder needs io_uio low through the capture stages
task automatic end_frame();
	next_cycle();
	gp_out[20] = 1'b0;
	repeat (4) next_cycle();
endtask

task automatic send_config(input logic [15:0] cfg);
	start_frame();
	write_word(16'h0001);
	write_word(cfg);
	end_frame();
endtask

// Code passes two capture stages and one more register
task automatic set_reset_code(input logic [1:0] code);
	next_cycle();
	gp_out[31:30] = code;
	repeat (4) next_cycle();
endtask

// ====================
// Sync waveforms
// ====================
// Hsync pulse 3 of 20 cycles and vsync pulse 6 of 60
task automatic run_sync(input logic active_low, input logic csync_on,
	input int warm, input int checked);
	int n;
	logic p_h;
	logic p_v;
	logic exp_hs;
	logic exp_vs;
	for (n = 0; n < warm + checked; n++) begin
		next_cycle();
		p_h = (n % 20) < 3;
		p_v = (n % 60) >= 30 && (n % 60) < 36;
		hs_in = p_h ^ active_low;
		vs_in = p_v ^ active_low;
		if (n >= warm) begin
			#1;
			exp_hs = vga_en ? 1'b1 : csync_on ? ~(p_h ^ p_v) : ~p_h;
			exp_vs = vga_en ? 1'b1 : csync_on ? 1'b1 : ~p_v;
			expect_eq(vga_hs, exp_hs, "vga_hs");
			expect_eq(vga_vs, exp_vs, "vga_vs");
		end
	end
endtask

// File: tb/tb_sys_top.sv
/*
 * Self-checking testbench for the board glue top level. Drives the host port,
 * buttons, reset codes and sync lines, and checks the responses with assertions.
 */
`timescale 1ns/1ps

module tb_sys_top;

	// ====================
	// Constants
	// ====================
	// Limit is many times the length of all tests
	localparam int max_cycles = 20000;
	localparam int debounce_div = 3;
	localparam int deb_len = 8;
	localparam int btn_limit = (deb_len + 2) * (debounce_div + 1);
	localparam int ack_limit = 20;
	localparam logic [31:0] magic_word = 32'h5CA6_23A4;
	// Status after reset holds only io_version in bits 19 to 18
	localparam logic [31:0] status_reset = 32'h0004_0000;
	localparam logic [11:0] timing_defaults [8] = '{
		12'd1280, 12'd110, 12'd40, 12'd220, 12'd720, 12'd5, 12'd5, 12'd20
	};

	logic        FPGA_CLK2_50;
	logic        resetd;
	logic [31:0] gp_out;
	logic [31:0] gp_in;
	logic        io_wait;
	logic        btn_user;
	logic        btn_osd;
	logic        btn_reset;
	logic [1:0]  key;
	logic        led_user_req;
	logic [1:0]  led_power_req;
	logic [1:0]  led_disk_req;
	logic        hs_in;
	logic        vs_in;
	logic        vga_en;
	logic        vga_hs;
	logic        vga_vs;
	logic        led_user;
	logic        led_hdd;
	logic        led_power;
	logic [7:0]  led;
	logic        reset_req;
	logic        cold_reset;
	logic        dvi_mode;
	logic        audio_96k;
	logic        ypbpr_en;
	logic        vga_scaler;
	logic [11:0] h_width;
	logic [11:0] h_fp;
	logic [11:0] h_sync;
	logic [11:0] h_bp;
	logic [11:0] v_height;
	logic [11:0] v_fp;
	logic [11:0] v_sync;
	logic [11:0] v_bp;
	logic        io_strobe;
	logic [15:0] io_data;
	logic [95:0] timing_bus;

	int    seed = 32'heec4d67f;
	int    errors = 0;
	int    errors_at_start = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    cycles = 0;
	string test_name;

	sys_top #(.debounce_div(debounce_div)) dut (.*);

	// Index 0 is h_width, index 7 is v_bp
	assign timing_bus = {v_bp, v_sync, v_fp, v_height, h_bp, h_sync, h_fp, h_width};

	always #2 FPGA_CLK2_50 = ~FPGA_CLK2_50;

	// Watchdog
	always @(posedge FPGA_CLK2_50) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", max_cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic open_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic close_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("Test %0d %s: passed", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed", tests_run, test_name);
		end
	endtask

	`include "host_tasks.svh"

	// ====================
	// Concurrent checks
	// ====================
	// Each io_clk rise gives a single-cycle strobe
	strobe_single: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		io_strobe |=> !io_strobe)
	else begin
		$display("MISMATCH at %0t: io_strobe high for more than one cycle", $time);
		errors++;
	end

	vga_off_high: assert property (@(posedge FPGA_CLK2_50) vga_en |-> (vga_hs && vga_vs))
	else begin
		$display("MISMATCH at %0t: VGA syncs not high with vga_en set", $time);
		errors++;
	end

	initial begin
		int          i;
		int          strobes;
		logic [15:0] cfg;
		logic [15:0] words [10];
		logic        exp_hdd;
		logic [7:0]  exp_led;

		FPGA_CLK2_50 = 1'b0;
		resetd = 1'b1;
		// Idle host state holds reset code 3 and reads status
		gp_out = 32'hC000_0000;
		io_wait = 1'b0;
		btn_user = 1'b1;
		btn_osd = 1'b1;
		btn_reset = 1'b1;
		key = 2'b11;
		led_user_req = 1'b0;
		led_power_req = 2'b00;
		led_disk_req = 2'b00;
		hs_in = 1'b0;
		vs_in = 1'b0;
		vga_en = 1'b0;
		repeat (5) @(posedge FPGA_CLK2_50);
		#1;
		resetd = 1'b0;

		open_test("magic and status words");
		next_cycle();
		// Guard code keeps reset_req clear while the magic is read
		gp_out[31:30] = 2'b00;
		#1;
		expect_eq(gp_in, magic_word, "gp_in with bit 31 low");
		next_cycle();
		gp_out[31:30] = 2'b11;
		#1;
		expect_eq(gp_in, status_reset, "status word after reset");
		for (i = 0; i < 8; i++)
			expect_eq(timing_bus[i*12 +: 12], timing_defaults[i], $sformatf("timing %0d", i));
		expect_eq(reset_req, 1'b0, "reset_req after reset");
		expect_eq(cold_reset, 1'b0, "cold_reset with button released");
		close_test();

		open_test("handshake");
		next_cycle();
		gp_out[17] = 1'b1;
		repeat (3) next_cycle();
		expect_eq(gp_in[17], 1'b0, "io_ack three cycles after io_clk rise");
		next_cycle();
		expect_eq(gp_in[17], 1'b1, "io_ack four cycles after io_clk rise");
		gp_out[17] = 1'b0;
		wait_status_bit(17, 1'b0, ack_limit);
		// Back-pressure from the core
		next_cycle();
		io_wait = 1'b1;
		gp_out[17] = 1'b1;
		strobes = 0;
		repeat (12) begin
			next_cycle();
			if (io_strobe)
				strobes++;
			expect_eq(gp_in[17], 1'b0, "io_ack while io_wait is high");
		end
		expect_eq(strobes, 1, "strobes taken under io_wait");
		io_wait = 1'b0;
		wait_status_bit(17, 1'b1, ack_limit);
		gp_out[17] = 1'b0;
		wait_status_bit(17, 1'b0, ack_limit);
		close_test();

		open_test("configuration word");
		cfg = 16'($random(seed));
		for (i = 0; i < 2; i++) begin
			send_config(cfg);
			expect_eq(dvi_mode, cfg[7], "dvi_mode");
			expect_eq(audio_96k, cfg[6], "audio_96k");
			expect_eq(ypbpr_en, cfg[5], "ypbpr_en");
			expect_eq(vga_scaler, cfg[2], "vga_scaler");
			// Complement makes every flag toggle
			cfg = ~cfg;
		end
		close_test();

		open_test("video timing words");
		start_frame();
		write_word(16'h0020);
		for (i = 0; i < 10; i++) begin
			words[i] = 16'($random(seed));
			write_word(words[i]);
		end
		end_frame();
		for (i = 0; i < 8; i++)
			expect_eq(timing_bus[i*12 +: 12], words[i][11:0], $sformatf("timing %0d", i));
		close_test();

		open_test("buttons and reset request");
		next_cycle();
		btn_user = 1'b0;
		wait_status_bit(30, 1'b1, btn_limit);
		expect_eq(gp_in[29], 1'b0, "OSD button bit");
		btn_user = 1'b1;
		wait_status_bit(30, 1'b0, btn_limit);
		// Bounce of two sample ticks
		btn_user = 1'b0;
		repeat (2 * (debounce_div + 1)) next_cycle();
		btn_user = 1'b1;
		repeat (btn_limit) begin
			next_cycle();
			expect_eq(gp_in[30], 1'b0, "user button after a short bounce");
		end
		set_reset_code(2'b00);
		set_reset_code(2'b10);
		expect_eq(reset_req, 1'b0, "reset_req after codes 0 and 2");
		set_reset_code(2'b01);
		expect_eq(reset_req, 1'b1, "reset_req after code 1");
		set_reset_code(2'b10);
		expect_eq(reset_req, 1'b1, "reset_req after code 2 without guard");
		set_reset_code(2'b00);
		set_reset_code(2'b10);
		expect_eq(reset_req, 1'b0, "reset_req after guarded clear");
		set_reset_code(2'b11);
		btn_reset = 1'b0;
		repeat (2) next_cycle();
		expect_eq(cold_reset, 1'b1, "cold_reset with button pressed");
		btn_reset = 1'b1;
		repeat (2) next_cycle();
		expect_eq(cold_reset, 1'b0, "cold_reset after button release");
		close_test();

		open_test("VGA sync");
		send_config(16'h0000);
		run_sync(1'b0, 1'b0, 180, 120);
		run_sync(1'b1, 1'b0, 180, 120);
		send_config(16'h0008);
		run_sync(1'b0, 1'b1, 180, 120);
		next_cycle();
		vga_en = 1'b1;
		run_sync(1'b0, 1'b1, 0, 120);
		next_cycle();
		vga_en = 1'b0;
		close_test();

		open_test("LED mapping");
		for (i = 0; i < 32; i++) begin
			next_cycle();
			led_user_req = i[0];
			led_power_req = {1'b1, i[1]};
			led_disk_req = i[3:2];
			gp_out[29] = i[4];
			// Disk activity passes the two capture stages
			repeat (2) next_cycle();
			if (i[3])
				exp_hdd = !i[2];
			else
				exp_hdd = !(i[2] || i[4]);
			exp_led = '0;
			exp_led[0] = i[0];
			exp_led[2] = !exp_hdd;
			exp_led[4] = i[1];
			expect_eq(led_user, !i[0], "led_user");
			expect_eq(led_power, !i[1], "led_power");
			expect_eq(led_hdd, exp_hdd, "led_hdd");
			expect_eq(led, exp_led, "led");
		end
		next_cycle();
		gp_out[29] = 1'b0;
		led_user_req = 1'b0;
		led_power_req = 2'b00;
		led_disk_req = 2'b00;
		close_test();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: sys_top.f
+incdir+tb
design/sys_pkg.sv
design/host_link.sv
design/config_decoder.sv
design/button_debounce.sv
design/reset_request.sv
design/video_sync_out.sv
design/sys_top.sv
tb/tb_sys_top.sv

// File: Makefile
# Verilator build for the board glue logic and its testbench

VERILATOR  = verilator
FILELIST   = sys_top.f
TB_TOP     = tb_sys_top
RTL_TOP    = sys_top
LINT_FLAGS = --lint-only --timing -Wall
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Pass or fail comes from the log, not the simulator exit code
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
